// File: snake_pkg.sv
package snake_pkg;

	// ########################################
	// field geometry
	// ########################################
	localparam int SCREEN_W = 160;
	localparam int SCREEN_H = 120;
	localparam int CELL_PX = 4;
	localparam int GRID_W = SCREEN_W / CELL_PX;
	localparam int GRID_H = SCREEN_H / CELL_PX;

	// start cells
	localparam int START_X = 5;
	localparam int START_Y = 5;
	localparam int APPLE_X0 = 10;
	localparam int APPLE_Y0 = 5;

	// apple stepping rule
	localparam int APPLE_STEP_X = 11;
	localparam int APPLE_STEP_Y = 7;
	localparam int INNER_LO = 3;

	// ps/2 break prefix
	localparam logic [7:0] KEY_BREAK = 8'hF0;

	// ########################################
	// types
	// ########################################
	typedef logic [7:0] pix_x_t;
	typedef logic [6:0] pix_y_t;
	typedef logic [5:0] cell_x_t;
	typedef logic [4:0] cell_y_t;
	typedef logic [7:0] score_t;
	typedef logic [4:0] len_t;
	typedef logic [2:0] diff_t;

	typedef enum logic [2:0] {
		MENU,
		GAME_INIT,
		GAME_WAIT,
		PLAYING,
		GAME_OVER
	} game_state_t;

	typedef enum logic [2:0] {
		DIR_NONE,
		DIR_UP,
		DIR_LEFT,
		DIR_DOWN,
		DIR_RIGHT
	} dir_t;

	typedef enum logic [2:0] {
		KEY_UP,
		KEY_LEFT,
		KEY_DOWN,
		KEY_RIGHT,
		KEY_ONE,
		KEY_TWO,
		KEY_THREE
	} key_t;

	// {r, g, b}
	typedef enum logic [2:0] {
		BLACK = 3'b000,
		RED   = 3'b100,
		GREEN = 3'b010,
		BLUE  = 3'b001,
		WHITE = 3'b111
	} colour_t;

endpackage

// File: ps2_keyboard.sv
`timescale 1ns/1ps

module ps2_keyboard
	import snake_pkg::*;
(
	input  logic clk,
	input  logic reset,
	input  logic ps2_clk,
	input  logic ps2_data,
	output logic key_strobe,
	output key_t key,
	output logic key_release
);

	logic [1:0]  clk_sync;
	logic [1:0]  data_sync;
	logic        clk_prev;
	logic        fall;
	logic [10:0] frame;
	logic [3:0]  bit_cnt;
	logic        frame_done;
	logic        code_valid;
	logic [7:0]  code;
	logic        brk;
	logic        map_valid;
	key_t        map_key;

	// two-flop synchronisers, lines idle high
	always_ff @(posedge clk) begin
		if (reset) begin
			clk_sync <= 2'b11;
			data_sync <= 2'b11;
			clk_prev <= 1'b1;
		end else begin
			clk_sync <= {clk_sync[0], ps2_clk};
			data_sync <= {data_sync[0], ps2_data};
			clk_prev <= clk_sync[1];
		end
	end

	assign fall = clk_prev & ~clk_sync[1];

	// ########################################
	// frame assembly, lsb first
	// ########################################
	always_ff @(posedge clk) begin
		if (fall) begin
			frame <= {data_sync[1], frame[10:1]};
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			bit_cnt <= '0;
			frame_done <= 1'b0;
		end else begin
			frame_done <= 1'b0;
			if (fall) begin
				if (bit_cnt == 4'd10) begin
					bit_cnt <= '0;
					frame_done <= 1'b1;
				end else begin
					bit_cnt <= bit_cnt + 4'd1;
				end
			end
		end
	end

	// start low, stop high, odd parity over data and parity bit
	always_ff @(posedge clk) begin
		if (reset) begin
			code_valid <= 1'b0;
		end else begin
			code_valid <= frame_done && !frame[0] && frame[10] && (^frame[9:1]);
		end
	end

	always_ff @(posedge clk) begin
		if (frame_done) begin
			code <= frame[8:1];
		end
	end

	// scan code table
	always_comb begin
		map_valid = 1'b1;
		map_key = KEY_UP;
		case (code)
			8'h75: map_key = KEY_UP;
			8'h6B: map_key = KEY_LEFT;
			8'h72: map_key = KEY_DOWN;
			8'h74: map_key = KEY_RIGHT;
			8'h16: map_key = KEY_ONE;
			8'h1E: map_key = KEY_TWO;
			8'h26: map_key = KEY_THREE;
			default: map_valid = 1'b0;
		endcase
	end

	// break flag covers exactly one following code
	always_ff @(posedge clk) begin
		if (reset) begin
			key_strobe <= 1'b0;
			brk <= 1'b0;
		end else begin
			key_strobe <= 1'b0;
			if (code_valid) begin
				if (code == KEY_BREAK) begin
					brk <= 1'b1;
				end else begin
					brk <= 1'b0;
					key_strobe <= map_valid;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (code_valid) begin
			key <= map_key;
			key_release <= brk;
		end
	end

endmodule

// File: game_fsm.sv
`timescale 1ns/1ps

module game_fsm
	import snake_pkg::*;
(
	input  logic        clk,
	input  logic        reset,
	input  logic        key_strobe,
	input  key_t        key,
	input  logic        key_release,
	input  logic        game_over,
	output game_state_t state,
	output diff_t       difficulty
);

	logic        is_digit;
	logic        is_arrow;
	logic        digit_rel;
	logic        arrow_press;
	game_state_t next_state;

	assign is_digit = key inside {KEY_ONE, KEY_TWO, KEY_THREE};
	assign is_arrow = key inside {KEY_UP, KEY_LEFT, KEY_DOWN, KEY_RIGHT};
	assign digit_rel = key_strobe && key_release && is_digit;
	assign arrow_press = key_strobe && !key_release && is_arrow;

	always_comb begin
		next_state = state;
		case (state)
			MENU: begin
				if (digit_rel) begin
					next_state = GAME_INIT;
				end
			end
			// single setup cycle for the engine
			GAME_INIT: next_state = GAME_WAIT;
			GAME_WAIT: begin
				if (arrow_press) begin
					next_state = PLAYING;
				end
			end
			PLAYING: begin
				if (game_over) begin
					next_state = GAME_OVER;
				end
			end
			GAME_OVER: begin
				if (digit_rel) begin
					next_state = MENU;
				end
			end
			default: next_state = MENU;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= MENU;
		end else begin
			state <= next_state;
		end
	end

	// move period in ticks, shorter is faster
	always_ff @(posedge clk) begin
		if (reset) begin
			difficulty <= 3'd4;
		end else if (state == MENU && digit_rel) begin
			case (key)
				KEY_ONE: difficulty <= 3'd4;
				KEY_TWO: difficulty <= 3'd2;
				default: difficulty <= 3'd1;
			endcase
		end
	end

endmodule

// File: move_timer.sv
`timescale 1ns/1ps

module move_timer
	import snake_pkg::*;
#(
	parameter int TICK_CYCLES = 1250000
) (
	input  logic        clk,
	input  logic        reset,
	input  game_state_t state,
	input  diff_t       difficulty,
	output logic        move_tick
);

	localparam int CW = $clog2(TICK_CYCLES + 1);

	logic [CW-1:0] cyc_cnt;
	diff_t         tick_cnt;
	logic          cyc_last;
	logic          tick_last;

	assign cyc_last = (cyc_cnt == CW'(TICK_CYCLES - 1));
	assign tick_last = (tick_cnt == difficulty - 3'd1);

	// both counters start from zero on each entry to playing
	always_ff @(posedge clk) begin
		if (reset || state != PLAYING) begin
			cyc_cnt <= '0;
			tick_cnt <= '0;
			move_tick <= 1'b0;
		end else begin
			move_tick <= cyc_last && tick_last;
			if (cyc_last) begin
				cyc_cnt <= '0;
				tick_cnt <= tick_last ? '0 : tick_cnt + 3'd1;
			end else begin
				cyc_cnt <= cyc_cnt + 1'b1;
			end
		end
	end

endmodule

// File: snake_engine.sv
`timescale 1ns/1ps

module snake_engine
	import snake_pkg::*;
#(
	parameter int MAX_LEN = 16
) (
	input  logic                  clk,
	input  logic                  reset,
	input  game_state_t           state,
	input  logic                  key_strobe,
	input  key_t                  key,
	input  logic                  key_release,
	input  logic                  move_tick,
	output logic                  game_over,
	output cell_x_t [MAX_LEN-1:0] body_x,
	output cell_y_t [MAX_LEN-1:0] body_y,
	output len_t                  length,
	output cell_x_t               apple_x,
	output cell_y_t               apple_y,
	output score_t                score,
	output score_t                hiscore
);

	dir_t    cur_dir;
	dir_t    pending_dir;
	dir_t    key_dir;
	logic    arrow_ok;
	logic    step;
	logic    fatal;
	logic    eat;
	logic    hit_border;
	logic    hit_body;
	cell_x_t nxt_x;
	cell_y_t nxt_y;
	cell_x_t sum_x;
	cell_y_t sum_y;
	cell_x_t new_apple_x;
	cell_y_t new_apple_y;
	score_t  score_inc;

	function automatic logic is_opposite(dir_t a, dir_t b);
		case (a)
			DIR_UP:    return b == DIR_DOWN;
			DIR_DOWN:  return b == DIR_UP;
			DIR_LEFT:  return b == DIR_RIGHT;
			DIR_RIGHT: return b == DIR_LEFT;
			default:   return 1'b0;
		endcase
	endfunction

	always_comb begin
		case (key)
			KEY_UP:    key_dir = DIR_UP;
			KEY_LEFT:  key_dir = DIR_LEFT;
			KEY_DOWN:  key_dir = DIR_DOWN;
			KEY_RIGHT: key_dir = DIR_RIGHT;
			default:   key_dir = DIR_NONE;
		endcase
	end

	assign arrow_ok = key_strobe && !key_release && key_dir != DIR_NONE
		&& (state == GAME_WAIT || state == PLAYING) && !is_opposite(key_dir, cur_dir);

	// ########################################
	// next head cell and its checks
	// ########################################
	always_comb begin
		nxt_x = body_x[0];
		nxt_y = body_y[0];
		case (pending_dir)
			DIR_UP:    nxt_y = body_y[0] - cell_y_t'(1);
			DIR_DOWN:  nxt_y = body_y[0] + cell_y_t'(1);
			DIR_LEFT:  nxt_x = body_x[0] - cell_x_t'(1);
			DIR_RIGHT: nxt_x = body_x[0] + cell_x_t'(1);
			default: ;
		endcase
		hit_border = nxt_x == '0 || nxt_x == cell_x_t'(GRID_W - 1)
			|| nxt_y == '0 || nxt_y == cell_y_t'(GRID_H - 1);
		hit_body = 1'b0;
		for (int i = 1; i < MAX_LEN; i++) begin
			if (i < int'(length) && body_x[i] == nxt_x && body_y[i] == nxt_y) begin
				hit_body = 1'b1;
			end
		end
	end

	assign step = move_tick && state == PLAYING && pending_dir != DIR_NONE;
	assign fatal = step && (hit_border || hit_body);
	assign eat = step && !fatal && nxt_x == apple_x && nxt_y == apple_y;
	assign score_inc = score + score_t'(1);

	// apple stays in the inner range, so one subtract does the modulo
	always_comb begin
		sum_x = apple_x - cell_x_t'(INNER_LO) + cell_x_t'(APPLE_STEP_X);
		if (sum_x >= cell_x_t'(GRID_W - 7)) begin
			sum_x = sum_x - cell_x_t'(GRID_W - 7);
		end
		sum_y = apple_y - cell_y_t'(INNER_LO) + cell_y_t'(APPLE_STEP_Y);
		if (sum_y >= cell_y_t'(GRID_H - 7)) begin
			sum_y = sum_y - cell_y_t'(GRID_H - 7);
		end
		new_apple_x = cell_x_t'(INNER_LO) + sum_x;
		new_apple_y = cell_y_t'(INNER_LO) + sum_y;
	end

	// ########################################
	// control state
	// ########################################
	always_ff @(posedge clk) begin
		if (reset) begin
			length <= len_t'(1);
			score <= '0;
			hiscore <= '0;
			cur_dir <= DIR_NONE;
			pending_dir <= DIR_NONE;
			game_over <= 1'b0;
		end else begin
			game_over <= fatal;
			if (state == GAME_INIT) begin
				length <= len_t'(1);
				score <= '0;
				cur_dir <= DIR_NONE;
				pending_dir <= DIR_NONE;
			end else begin
				if (arrow_ok) begin
					pending_dir <= key_dir;
				end
				if (step) begin
					cur_dir <= pending_dir;
				end
				if (eat) begin
					if (int'(length) < MAX_LEN) begin
						length <= length + len_t'(1);
					end
					score <= score_inc;
					if (score_inc > hiscore) begin
						hiscore <= score_inc;
					end
				end
			end
		end
	end

	// body and apple cells
	always_ff @(posedge clk) begin
		if (state == GAME_INIT) begin
			body_x[0] <= cell_x_t'(START_X);
			body_y[0] <= cell_y_t'(START_Y);
			apple_x <= cell_x_t'(APPLE_X0);
			apple_y <= cell_y_t'(APPLE_Y0);
		end else if (step && !fatal) begin
			for (int i = MAX_LEN - 1; i > 0; i--) begin
				body_x[i] <= body_x[i-1];
				body_y[i] <= body_y[i-1];
			end
			body_x[0] <= nxt_x;
			body_y[0] <= nxt_y;
			if (eat) begin
				apple_x <= new_apple_x;
				apple_y <= new_apple_y;
			end
		end
	end

endmodule

// File: pixel_renderer.sv
`timescale 1ns/1ps

module pixel_renderer
	import snake_pkg::*;
#(
	parameter int MAX_LEN = 16
) (
	input  logic                  clk,
	input  logic                  reset,
	input  game_state_t           state,
	input  cell_x_t [MAX_LEN-1:0] body_x,
	input  cell_y_t [MAX_LEN-1:0] body_y,
	input  len_t                  length,
	input  cell_x_t               apple_x,
	input  cell_y_t               apple_y,
	output pix_x_t                x,
	output pix_y_t                y,
	output colour_t               colour
);

	pix_x_t  x_nxt;
	pix_y_t  y_nxt;
	cell_x_t cx;
	cell_y_t cy;
	logic    in_border;
	logic    on_snake;
	logic    in_game;
	colour_t colour_nxt;

	// raster scan
	always_comb begin
		x_nxt = x + pix_x_t'(1);
		y_nxt = y;
		if (x == pix_x_t'(SCREEN_W - 1)) begin
			x_nxt = '0;
			y_nxt = (y == pix_y_t'(SCREEN_H - 1)) ? '0 : y + pix_y_t'(1);
		end
	end

	// colour goes out together with the coordinate it belongs to
	assign cx = cell_x_t'(x_nxt / CELL_PX);
	assign cy = cell_y_t'(y_nxt / CELL_PX);
	assign in_game = state == GAME_WAIT || state == PLAYING;
	assign in_border = cx == '0 || cx == cell_x_t'(GRID_W - 1)
		|| cy == '0 || cy == cell_y_t'(GRID_H - 1);

	always_comb begin
		on_snake = 1'b0;
		for (int i = 0; i < MAX_LEN; i++) begin
			if (i < int'(length) && body_x[i] == cx && body_y[i] == cy) begin
				on_snake = 1'b1;
			end
		end
	end

	always_comb begin
		colour_nxt = BLACK;
		if (in_border) begin
			case (state)
				MENU:      colour_nxt = WHITE;
				GAME_WAIT: colour_nxt = BLUE;
				PLAYING:   colour_nxt = BLUE;
				GAME_OVER: colour_nxt = RED;
				default:   colour_nxt = BLACK;
			endcase
		end else if (in_game && on_snake) begin
			colour_nxt = GREEN;
		end else if (in_game && cx == apple_x && cy == apple_y) begin
			colour_nxt = RED;
		end
	end

	// (0,0) is a border pixel of the menu screen
	always_ff @(posedge clk) begin
		if (reset) begin
			x <= '0;
			y <= '0;
			colour <= WHITE;
		end else begin
			x <= x_nxt;
			y <= y_nxt;
			colour <= colour_nxt;
		end
	end

endmodule

// File: snake_top.sv
`timescale 1ns/1ps

module snake_top
	import snake_pkg::*;
#(
	parameter int TICK_CYCLES = 1250000,
	parameter int MAX_LEN = 16
) (
	input  logic        clk,
	input  logic        reset,
	input  logic        ps2_clk,
	input  logic        ps2_data,
	output pix_x_t      x,
	output pix_y_t      y,
	output colour_t     colour,
	output game_state_t state,
	output score_t      score,
	output score_t      hiscore
);

	logic                  key_strobe;
	key_t                  key;
	logic                  key_release;
	logic                  game_over;
	logic                  move_tick;
	diff_t                 difficulty;
	cell_x_t [MAX_LEN-1:0] body_x;
	cell_y_t [MAX_LEN-1:0] body_y;
	len_t                  length;
	cell_x_t               apple_x;
	cell_y_t               apple_y;

	ps2_keyboard u_keyboard (
		.clk(clk),
		.reset(reset),
		.ps2_clk(ps2_clk),
		.ps2_data(ps2_data),
		.key_strobe(key_strobe),
		.key(key),
		.key_release(key_release)
	);

	game_fsm u_fsm (
		.clk(clk),
		.reset(reset),
		.key_strobe(key_strobe),
		.key(key),
		.key_release(key_release),
		.game_over(game_over),
		.state(state),
		.difficulty(difficulty)
	);

	move_timer #(.TICK_CYCLES(TICK_CYCLES)) u_timer (
		.clk(clk),
		.reset(reset),
		.state(state),
		.difficulty(difficulty),
		.move_tick(move_tick)
	);

	snake_engine #(.MAX_LEN(MAX_LEN)) u_engine (
		.clk(clk),
		.reset(reset),
		.state(state),
		.key_strobe(key_strobe),
		.key(key),
		.key_release(key_release),
		.move_tick(move_tick),
		.game_over(game_over),
		.body_x(body_x),
		.body_y(body_y),
		.length(length),
		.apple_x(apple_x),
		.apple_y(apple_y),
		.score(score),
		.hiscore(hiscore)
	);

	pixel_renderer #(.MAX_LEN(MAX_LEN)) u_renderer (
		.clk(clk),
		.reset(reset),
		.state(state),
		.body_x(body_x),
		.body_y(body_y),
		.length(length),
		.apple_x(apple_x),
		.apple_y(apple_y),
		.x(x),
		.y(y),
		.colour(colour)
	);

endmodule

// File: tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int PERIOD_NS = 20,
	parameter int RESET_CYCLES = 3
) (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	// release on a falling edge, clear of the sampling edge
	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
	end

endmodule

// File: snake_sva.sv
`timescale 1ns/1ps

module snake_sva
	import snake_pkg::*;
(
	input logic        clk,
	input logic        reset,
	input game_state_t state,
	input pix_x_t      x,
	input pix_y_t      y,
	input score_t      score,
	input score_t      hiscore
);

	// engine setup is a single cycle
	a_init_once: assert property (@(posedge clk) disable iff (reset)
		state == GAME_INIT |=> state != GAME_INIT)
		else $error("GAME_INIT held for more than one cycle");

	a_scan_range: assert property (@(posedge clk) disable iff (reset)
		x < pix_x_t'(SCREEN_W) && y < pix_y_t'(SCREEN_H))
		else $error("scanner left the pixel field");

	a_score_le_hi: assert property (@(posedge clk) disable iff (reset)
		score <= hiscore)
		else $error("score above high score");

	// playing ends only in game over
	a_play_exit: assert property (@(posedge clk) disable iff (reset)
		state == PLAYING |=> state == PLAYING || state == GAME_OVER)
		else $error("PLAYING left to a state other than GAME_OVER");

endmodule

bind snake_top snake_sva u_sva (
	.clk(clk),
	.reset(reset),
	.state(state),
	.x(x),
	.y(y),
	.score(score),
	.hiscore(hiscore)
);

// File: snake_tb.sv
`timescale 1ns/1ps

module snake_tb
	import snake_pkg::*;
();

	localparam int TICK_CYCLES = 16;
	localparam int MAX_LEN = 16;
	localparam int CLK_NS = 20;
	localparam int PS2_HALF = 8;
	localparam int FRAME_CYCLES = 11 * 2 * PS2_HALF + 1;
	localparam int GAP_MIN = 20;
	localparam int GAP_MAX = 100;
	localparam int MAX_FRAMES = 40;
	localparam int SCAN_CYCLES = SCREEN_W * SCREEN_H;
	localparam int NUM_ROWS = 3;

	typedef struct packed {
		key_t   digit;
		key_t   first;
		logic   turn;
		key_t   second;
		score_t exp_score;
		score_t exp_hi;
		int     exp_moves;
	} scenario_t;

	logic        clk;
	logic        reset;
	logic        ps2_clk;
	logic        ps2_data;
	pix_x_t      x;
	pix_y_t      y;
	colour_t     colour;
	game_state_t state;
	score_t      score;
	score_t      hiscore;

	scenario_t   rows [NUM_ROWS];
	int          errors;
	logic        saw_init;
	time         play_start;
	game_state_t last_state = MENU;
	int          scan_pos;

	tb_clock_gen #(.PERIOD_NS(CLK_NS), .RESET_CYCLES(3)) u_clock (
		.clk(clk),
		.reset(reset)
	);

	snake_top #(.TICK_CYCLES(TICK_CYCLES), .MAX_LEN(MAX_LEN)) u_dut (
		.clk(clk),
		.reset(reset),
		.ps2_clk(ps2_clk),
		.ps2_data(ps2_data),
		.x(x),
		.y(y),
		.colour(colour),
		.state(state),
		.score(score),
		.hiscore(hiscore)
	);

	// state history for the pace measurement
	always @(negedge clk) begin
		if (state == GAME_INIT) begin
			saw_init = 1'b1;
		end
		if (state == PLAYING && last_state != PLAYING) begin
			play_start = $time;
		end
		last_state = state;
	end

	// cycles since reset give the raster position
	always @(posedge clk) begin
		if (reset) begin
			scan_pos <= 0;
		end else begin
			scan_pos <= (scan_pos + 1) % SCAN_CYCLES;
		end
	end

	// ########################################
	// ps/2 driver
	// ########################################
	function automatic logic [7:0] scan_code(input key_t k);
		case (k)
			KEY_UP:    return 8'h75;
			KEY_LEFT:  return 8'h6B;
			KEY_DOWN:  return 8'h72;
			KEY_RIGHT: return 8'h74;
			KEY_ONE:   return 8'h16;
			KEY_TWO:   return 8'h1E;
			default:   return 8'h26;
		endcase
	endfunction

	// start, data lsb first, odd parity, stop
	task automatic send_frame(input logic [7:0] code);
		logic [10:0] bits;
		bits = {1'b1, ~^code, code, 1'b0};
		@(negedge clk);
		for (int i = 0; i < 11; i++) begin
			ps2_data = bits[i];
			repeat (PS2_HALF) @(negedge clk);
			ps2_clk = 1'b0;
			repeat (PS2_HALF) @(negedge clk);
			ps2_clk = 1'b1;
		end
	endtask

	task automatic idle_gap();
		int gap;
		gap = $urandom_range(GAP_MAX, GAP_MIN);
		repeat (gap) @(negedge clk);
	endtask

	task automatic press_key(input key_t k);
		send_frame(scan_code(k));
		idle_gap();
	endtask

	task automatic tap_key(input key_t k);
		press_key(k);
		send_frame(KEY_BREAK);
		idle_gap();
		press_key(k);
	endtask

	// ########################################
	// compare tasks
	// ########################################
	task automatic check_state(input game_state_t got, input game_state_t exp,
		input string what);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s is %s, expected %s", $time, what,
				got.name(), exp.name());
			errors++;
		end
	endtask

	task automatic check_score(input score_t got, input score_t exp, input string what);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic check_colour(input colour_t got, input colour_t exp, input string what);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s is %s, expected %s", $time, what,
				got.name(), exp.name());
			errors++;
		end
	endtask

	task automatic check_pos(input pix_x_t got_x, input pix_y_t got_y, input pix_x_t exp_x,
		input pix_y_t exp_y, input string what);
		if (got_x !== exp_x || got_y !== exp_y) begin
			$display("Mismatch at %0t: %s is (%0d,%0d), expected (%0d,%0d)", $time, what,
				got_x, got_y, exp_x, exp_y);
			errors++;
		end
	endtask

	task automatic check_moves(input int got, input int exp, input string what);
		if (got < exp - 1 || got > exp + 1) begin
			$display("Mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic wait_state(input game_state_t target, input int max_cycles);
		int cycles;
		cycles = 0;
		while (state != target && cycles < max_cycles) begin
			@(negedge clk);
			cycles++;
		end
		if (state != target) begin
			$display("Timed out at %0t waiting for state %s, state stayed %s", $time,
				target.name(), state.name());
			errors++;
		end
	endtask

	task automatic wait_score(input score_t target, input int max_cycles);
		int cycles;
		cycles = 0;
		while (score != target && cycles < max_cycles) begin
			@(negedge clk);
			cycles++;
		end
		if (score != target) begin
			$display("Timed out at %0t waiting for score %0d", $time, target);
			errors++;
		end
	endtask

	// colour from the field rules, with the start snake and first apple
	function automatic colour_t expected_colour(input int px, input int py,
		input colour_t border_col, input logic show_start);
		int cx;
		int cy;
		cx = px / CELL_PX;
		cy = py / CELL_PX;
		if (cx == 0 || cx == GRID_W - 1 || cy == 0 || cy == GRID_H - 1) begin
			return border_col;
		end
		if (show_start && cx == START_X && cy == START_Y) begin
			return GREEN;
		end
		if (show_start && cx == APPLE_X0 && cy == APPLE_Y0) begin
			return RED;
		end
		return BLACK;
	endfunction

	task automatic check_scan(input colour_t border_col, input logic show_start,
		input string what);
		pix_x_t exp_x;
		pix_y_t exp_y;
		for (int i = 0; i < SCAN_CYCLES; i++) begin
			@(negedge clk);
			exp_x = pix_x_t'(scan_pos % SCREEN_W);
			exp_y = pix_y_t'(scan_pos / SCREEN_W);
			check_pos(x, y, exp_x, exp_y, $sformatf("%s scan position", what));
			check_colour(colour, expected_colour(int'(exp_x), int'(exp_y), border_col,
				show_start), $sformatf("%s pixel (%0d,%0d)", what, exp_x, exp_y));
		end
	endtask

	function automatic int move_period(input key_t digit);
		case (digit)
			KEY_ONE: return 4 * TICK_CYCLES;
			KEY_TWO: return 2 * TICK_CYCLES;
			default: return TICK_CYCLES;
		endcase
	endfunction

	task automatic run_watchdog(input longint limit_cycles);
		#(limit_cycles * CLK_NS);
		$display("Watchdog expired after %0d cycles, the run is stuck", limit_cycles);
		$display("Test failed");
		$finish;
	endtask

	// ########################################
	// main sequence
	// ########################################
	initial begin
		longint limit;
		int     period;
		int     exp_moves;
		int     measured;
		int     right_moves;
		time    turn_t;
		score_t prev_hi;

		void'($urandom(32'h24fa));
		ps2_clk = 1'b1;
		ps2_data = 1'b1;
		errors = 0;
		saw_init = 1'b0;
		play_start = 0;

		// digit, first arrow, turn, second arrow, score, hiscore, moves (0 is computed)
		rows[0] = '{KEY_THREE, KEY_RIGHT, 1'b0, KEY_RIGHT, 8'd1, 8'd1, 33};
		rows[1] = '{KEY_TWO, KEY_RIGHT, 1'b1, KEY_DOWN, 8'd1, 8'd1, 0};
		rows[2] = '{KEY_ONE, KEY_UP, 1'b0, KEY_UP, 8'd0, 8'd1, 4};

		limit = 3 * SCAN_CYCLES + MAX_FRAMES * (FRAME_CYCLES + GAP_MAX + 2);
		for (int r = 0; r < NUM_ROWS; r++) begin
			if (rows[r].exp_moves == 0) begin
				limit += (GRID_W + GRID_H + 10) * 4 * TICK_CYCLES;
			end else begin
				limit += (rows[r].exp_moves + 10) * 4 * TICK_CYCLES;
			end
		end

		wait (!reset);
		fork
			run_watchdog(limit);
		join_none
		@(negedge clk);

		// menu after reset
		check_state(state, MENU, "state after reset");
		check_score(score, 8'd0, "score after reset");
		check_score(hiscore, 8'd0, "hiscore after reset");
		check_scan(WHITE, 1'b0, "menu");
		press_key(KEY_RIGHT);
		send_frame(8'h1C);
		idle_gap();
		check_state(state, MENU, "state after arrow and unknown code in menu");

		prev_hi = 8'd0;
		for (int r = 0; r < NUM_ROWS; r++) begin
			period = move_period(rows[r].digit);
			if (state == GAME_OVER) begin
				tap_key(rows[r].digit);
				wait_state(MENU, 50);
				check_state(state, MENU, "state after digit in game over");
			end

			saw_init = 1'b0;
			tap_key(rows[r].digit);
			wait_state(GAME_WAIT, 50);
			check_state(state, GAME_WAIT, "state after digit in menu");
			if (!saw_init) begin
				$display("State did not pass through GAME_INIT before %0t", $time);
				errors++;
			end
			check_score(score, 8'd0, "score at game start");
			check_score(hiscore, prev_hi, "hiscore at game start");
			if (r == 0) begin
				check_scan(BLUE, 1'b1, "waiting field");
			end

			press_key(rows[r].first);
			exp_moves = rows[r].exp_moves;
			if (rows[r].turn) begin
				wait_score(8'd1, 10 * period);
				send_frame(scan_code(rows[r].second));
				turn_t = $time;
				idle_gap();
				// head cell at the turn, then straight down to the last inner row
				right_moves = int'((turn_t - play_start) / (period * CLK_NS));
				exp_moves = (START_X + right_moves - START_X) + (GRID_H - 2 - START_Y);
			end

			wait_state(GAME_OVER, (GRID_W + GRID_H + 4) * period);
			// the fatal tick comes one period after the last move
			measured = int'(($time - play_start) / (period * CLK_NS)) - 1;
			check_moves(measured, exp_moves, $sformatf("move count in game %0d", r));
			check_state(state, GAME_OVER, "state at end of game");
			check_score(score, rows[r].exp_score, "final score");
			check_score(hiscore, rows[r].exp_hi, "final hiscore");
			if (r == 0) begin
				check_scan(RED, 1'b0, "game over field");
			end
			prev_hi = rows[r].exp_hi;
		end

		// restart keeps the high score
		tap_key(KEY_TWO);
		wait_state(MENU, 50);
		check_state(state, MENU, "state after restart");
		check_score(hiscore, prev_hi, "hiscore in menu after restart");
		tap_key(KEY_TWO);
		wait_state(GAME_WAIT, 50);
		check_score(score, 8'd0, "score in new game");
		check_score(hiscore, prev_hi, "hiscore in new game");

		$display("Run finished with %0d errors", errors);
		if (errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// File: snake_top.f
snake_pkg.sv
ps2_keyboard.sv
game_fsm.sv
move_timer.sv
snake_engine.sv
pixel_renderer.sv
snake_top.sv
tb_clock_gen.sv
snake_sva.sv
snake_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module snake_tb -f snake_top.f

out=$(./obj_dir/Vsnake_tb)
echo "$out"

if echo "$out" | grep -q "Test completed successfully"; then
	exit 0
fi
exit 1
